/* src/cpu_pkg.sv */
package cpu_pkg;

    // datapath widths
    localparam int DATA_W     = 8;              // register and memory word
    localparam int PC_W       = 32;             // pc and instruction word
    localparam int REG_ADDR_W = 3;              // eight registers
    localparam int OPCODE_W   = 8;
    localparam int ALU_OP_W   = 2;

    // instruction field positions
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 24;
    localparam int OFFSET_MSB = 23;             // signed word offset for j/beq/bne
    localparam int OFFSET_LSB = 16;
    localparam int DEST_MSB   = 18;             // overlaps offset but never used with it
    localparam int DEST_LSB   = 16;
    localparam int SRC1_MSB   = 10;
    localparam int SRC1_LSB   = 8;
    localparam int SRC2_MSB   = 2;
    localparam int SRC2_LSB   = 0;
    localparam int IMM_MSB    = 7;              // overlaps src2
    localparam int IMM_LSB    = 0;

    // opcodes of the instruction encoding
    typedef enum logic [OPCODE_W-1:0] {
        OP_LOADI = 8'd0,
        OP_MOV   = 8'd1,
        OP_ADD   = 8'd2,
        OP_SUB   = 8'd3,
        OP_AND   = 8'd4,
        OP_OR    = 8'd5,
        OP_J     = 8'd6,
        OP_BEQ   = 8'd7,
        OP_BNE   = 8'd13,                       // 8..12 are undecoded and run as nops
        OP_LWD   = 8'd14,
        OP_SWD   = 8'd16
    } opcode_e;

    // alu functions
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_FWD = 2'd0,                         // pass selected operand through
        ALU_ADD = 2'd1,
        ALU_AND = 2'd2,
        ALU_OR  = 2'd3
    } alu_op_e;

endpackage

/* src/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  cpu_pkg::opcode_e opcode,
    output cpu_pkg::alu_op_e alu_op,
    output logic             alu_src,      // 1 selects immediate as operand 2
    output logic             negate,       // two's complement of operand 2
    output logic             reg_write,
    output logic             branch,
    output logic             branch_ne,    // branch on not equal
    output logic             jump,
    output logic             mem_read,
    output logic             mem_write,
    output logic             wb_from_mem   // write back readdata instead of alu result
);

    always_comb
    begin
        // everything off by default so unknown opcodes become nops
        alu_op      = cpu_pkg::ALU_FWD;
        alu_src     = 1'b0;
        negate      = 1'b0;
        reg_write   = 1'b0;
        branch      = 1'b0;
        branch_ne   = 1'b0;
        jump        = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        wb_from_mem = 1'b0;
        case (opcode)
            cpu_pkg::OP_LOADI:
            begin
                alu_src   = 1'b1;                  // forward the immediate
                reg_write = 1'b1;
            end
            cpu_pkg::OP_MOV:
            begin
                reg_write = 1'b1;                  // forward src2
            end
            cpu_pkg::OP_ADD:
            begin
                alu_op    = cpu_pkg::ALU_ADD;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_SUB:
            begin
                alu_op    = cpu_pkg::ALU_ADD;      // src1 + (-src2)
                negate    = 1'b1;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_AND:
            begin
                alu_op    = cpu_pkg::ALU_AND;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_OR:
            begin
                alu_op    = cpu_pkg::ALU_OR;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_J:
            begin
                jump = 1'b1;                       // alu result unused
            end
            cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE:
            begin
                alu_op    = cpu_pkg::ALU_ADD;      // zero flag set when equal
                negate    = 1'b1;
                branch    = 1'b1;
                branch_ne = (opcode == cpu_pkg::OP_BNE);
            end
            cpu_pkg::OP_LWD:
            begin
                reg_write   = 1'b1;                // address is src2 forwarded
                mem_read    = 1'b1;
                wb_from_mem = 1'b1;
            end
            cpu_pkg::OP_SWD:
            begin
                mem_write = 1'b1;                  // data from src1, address from src2
            end
            default:
            begin
                alu_op = cpu_pkg::ALU_FWD;         // illegal opcode, nothing enabled
            end
        endcase
    end

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::DATA_W-1:0] op1,
    input  logic [cpu_pkg::DATA_W-1:0] op2,
    input  logic [cpu_pkg::DATA_W-1:0] imm,
    input  cpu_pkg::alu_op_e           alu_op,
    input  logic                       alu_src,
    input  logic                       negate,
    output logic [cpu_pkg::DATA_W-1:0] result,
    output logic                       zero
);

    logic [cpu_pkg::DATA_W-1:0] selected;         // register or immediate
    logic [cpu_pkg::DATA_W-1:0] operand;          // after optional negation

    assign selected = alu_src ? imm : op2;
    assign operand  = negate ? (~selected + 1'b1) : selected;

    always_comb
    begin
        result = operand;                         // fwd, also covers mov/loadi/lwd/swd
        case (alu_op)
            cpu_pkg::ALU_ADD: result = op1 + operand;   // wraps at 8 bits
            cpu_pkg::ALU_AND: result = op1 & operand;
            cpu_pkg::ALU_OR:  result = op1 | operand;
            default:          result = operand;
        endcase
    end

    // beq/bne compare by subtraction
    assign zero = (result == '0);

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                           CLK,
    input  logic                           rst_n,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] write_addr,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] read_addr1,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] read_addr2,
    input  logic [cpu_pkg::DATA_W-1:0]     write_data,
    input  logic                           write_en,
    output logic [cpu_pkg::DATA_W-1:0]     read_data1,
    output logic [cpu_pkg::DATA_W-1:0]     read_data2
);

    localparam int NUM_REGS = 1 << cpu_pkg::REG_ADDR_W;

    logic [cpu_pkg::DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;                       // all registers start at zero
            end
        end
        else if (write_en)
        begin
            regs[write_addr] <= write_data;          // write_en already includes commit
        end
    end

    // asynchronous reads, the new value is visible after the edge
    assign read_data1 = regs[read_addr1];
    assign read_data2 = regs[read_addr2];

endmodule

/* src/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit #(
    parameter logic [cpu_pkg::PC_W-1:0] RESET_PC = '0
) (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic [cpu_pkg::DATA_W-1:0] offset,     // signed, in words
    input  logic                       branch,
    input  logic                       branch_ne,
    input  logic                       jump,
    input  logic                       zero,
    input  logic                       advance,    // low while memory stalls
    output logic [cpu_pkg::PC_W-1:0]   pc
);

    localparam int EXT_W = cpu_pkg::PC_W - cpu_pkg::DATA_W - 2;

    logic [cpu_pkg::PC_W-1:0] pc_seq;              // pc + 4
    logic [cpu_pkg::PC_W-1:0] byte_offset;         // sign extended, times 4
    logic [cpu_pkg::PC_W-1:0] pc_target;
    logic [cpu_pkg::PC_W-1:0] pc_next;
    logic                     take;

    assign pc_seq      = pc + 32'd4;
    assign byte_offset = {{EXT_W{offset[cpu_pkg::DATA_W-1]}}, offset, 2'b00};
    assign pc_target   = pc_seq + byte_offset;     // relative to next instruction

    // beq takes on zero, bne on not zero
    assign take    = jump | (branch & (zero ^ branch_ne));
    assign pc_next = take ? pc_target : pc_seq;

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc <= RESET_PC;
        end
        else if (advance)
        begin
            pc <= pc_next;                         // hold through busywait
        end
    end

endmodule

/* src/cpu.sv */
`timescale 1ns/1ps

module cpu #(
    parameter logic [cpu_pkg::PC_W-1:0] RESET_PC = '0
) (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic [cpu_pkg::PC_W-1:0]   instruction,
    output logic [cpu_pkg::PC_W-1:0]   pc,
    // data memory
    output logic                       read,
    output logic                       write,
    output logic [cpu_pkg::DATA_W-1:0] address,
    output logic [cpu_pkg::DATA_W-1:0] writedata,
    input  logic [cpu_pkg::DATA_W-1:0] readdata,
    input  logic                       busywait
);

    cpu_pkg::opcode_e opcode;
    cpu_pkg::alu_op_e alu_op;

    logic alu_src;
    logic negate;
    logic reg_write;
    logic branch;
    logic branch_ne;
    logic jump;
    logic mem_read;
    logic mem_write;
    logic wb_from_mem;
    logic zero;
    logic advance;                                    // instruction commits this edge

    logic [cpu_pkg::DATA_W-1:0] read_data1;
    logic [cpu_pkg::DATA_W-1:0] read_data2;
    logic [cpu_pkg::DATA_W-1:0] alu_result;
    logic [cpu_pkg::DATA_W-1:0] wb_data;

    assign opcode = cpu_pkg::opcode_e'(instruction[cpu_pkg::OPCODE_MSB:cpu_pkg::OPCODE_LSB]);

    control_unit u_control_unit (
        .opcode      (opcode),
        .alu_op      (alu_op),
        .alu_src     (alu_src),
        .negate      (negate),
        .reg_write   (reg_write),
        .branch      (branch),
        .branch_ne   (branch_ne),
        .jump        (jump),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .wb_from_mem (wb_from_mem)
    );

    // non memory ops commit every edge, memory ops when busywait drops
    assign advance = ~(mem_read | mem_write) | ~busywait;

    assign wb_data = wb_from_mem ? readdata : alu_result;

    reg_file u_reg_file (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .write_addr (instruction[cpu_pkg::DEST_MSB:cpu_pkg::DEST_LSB]),
        .read_addr1 (instruction[cpu_pkg::SRC1_MSB:cpu_pkg::SRC1_LSB]),
        .read_addr2 (instruction[cpu_pkg::SRC2_MSB:cpu_pkg::SRC2_LSB]),
        .write_data (wb_data),
        .write_en   (reg_write & advance),            // lwd waits for readdata
        .read_data1 (read_data1),
        .read_data2 (read_data2)
    );

    alu u_alu (
        .op1     (read_data1),
        .op2     (read_data2),
        .imm     (instruction[cpu_pkg::IMM_MSB:cpu_pkg::IMM_LSB]),
        .alu_op  (alu_op),
        .alu_src (alu_src),
        .negate  (negate),
        .result  (alu_result),
        .zero    (zero)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc_unit (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .offset    (instruction[cpu_pkg::OFFSET_MSB:cpu_pkg::OFFSET_LSB]),
        .branch    (branch),
        .branch_ne (branch_ne),
        .jump      (jump),
        .zero      (zero),
        .advance   (advance),
        .pc        (pc)
    );

    // memory port, held for the whole access
    assign read      = mem_read;
    assign write     = mem_write;
    assign address   = alu_result;                    // src2 forwarded
    assign writedata = read_data1;

endmodule

/* sim/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker #(
    parameter logic [cpu_pkg::PC_W-1:0] RESET_PC = '0
) (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic [cpu_pkg::PC_W-1:0]   instruction,
    input  logic [cpu_pkg::PC_W-1:0]   pc,
    input  logic                       read,
    input  logic                       write,
    input  logic [cpu_pkg::DATA_W-1:0] address,
    input  logic [cpu_pkg::DATA_W-1:0] writedata,
    input  logic [cpu_pkg::DATA_W-1:0] readdata,
    input  logic                       busywait,
    output int                         error_count,
    output int                         commit_count
);

    logic [cpu_pkg::DATA_W-1:0] regs_m [8];                // model registers
    logic [cpu_pkg::PC_W-1:0]   pc_m;                      // expected pc
    bit                         reset_seen = 1'b0;         // dut reset has taken effect
    int                         errors     = 0;
    int                         commits    = 0;

    assign error_count  = errors;
    assign commit_count = commits;

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // one edge of the instruction set model, inputs are the pre-edge values
    task automatic step();
        logic [7:0]  op;
        logic [7:0]  src1;
        logic [7:0]  src2;
        logic [2:0]  dest;
        logic [7:0]  off;
        logic [31:0] target;
        logic        mem_op;
        op     = instruction[cpu_pkg::OPCODE_MSB:cpu_pkg::OPCODE_LSB];
        src1   = regs_m[instruction[cpu_pkg::SRC1_MSB:cpu_pkg::SRC1_LSB]];
        src2   = regs_m[instruction[cpu_pkg::SRC2_MSB:cpu_pkg::SRC2_LSB]];
        dest   = instruction[cpu_pkg::DEST_MSB:cpu_pkg::DEST_LSB];
        off    = instruction[cpu_pkg::OFFSET_MSB:cpu_pkg::OFFSET_LSB];
        target = pc_m + 32'd4 + ({{24{off[7]}}, off} << 2);   // word offset from next pc
        mem_op = (op == cpu_pkg::OP_LWD) || (op == cpu_pkg::OP_SWD);
        compare("pc", pc_m, pc);
        compare("read", op == cpu_pkg::OP_LWD, read);
        compare("write", op == cpu_pkg::OP_SWD, write);
        if (!mem_op || !busywait)                          // commit edge
        begin
            commits++;
            pc_m = pc_m + 32'd4;
            case (op)
                cpu_pkg::OP_LOADI: regs_m[dest] = instruction[cpu_pkg::IMM_MSB:cpu_pkg::IMM_LSB];
                cpu_pkg::OP_MOV:   regs_m[dest] = src2;
                cpu_pkg::OP_ADD:   regs_m[dest] = src1 + src2;       // mod 256
                cpu_pkg::OP_SUB:   regs_m[dest] = src1 - src2;
                cpu_pkg::OP_AND:   regs_m[dest] = src1 & src2;
                cpu_pkg::OP_OR:    regs_m[dest] = src1 | src2;
                cpu_pkg::OP_J:     pc_m = target;
                cpu_pkg::OP_BEQ:   pc_m = (src1 == src2) ? target : pc_m;
                cpu_pkg::OP_BNE:   pc_m = (src1 != src2) ? target : pc_m;
                cpu_pkg::OP_LWD:
                begin
                    compare("address", src2, address);
                    regs_m[dest] = readdata;               // memory data valid this cycle
                end
                cpu_pkg::OP_SWD:
                begin
                    compare("address", src2, address);
                    compare("writedata", src1, writedata);
                end
                default: ;                                 // illegal opcode, pc + 4 only
            endcase
        end
    endtask

    always @(posedge CLK)
    begin
        if (!rst_n)
        begin
            pc_m = RESET_PC;
            for (int i = 0; i < 8; i++)
                regs_m[i] = '0;
            if (reset_seen)
                compare("pc", RESET_PC, pc);
            compare("read", 1'b0, read);
            compare("write", 1'b0, write);
            reset_seen = 1'b1;
        end
        else
        begin
            step();
        end
    end

endmodule

/* sim/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    localparam logic [31:0] RESET_PC  = 32'h0000_0400;
    localparam int          SEED      = 18558;
    localparam int          NUM_INSTR = 800;
    localparam int          REQ_LIMIT = 4;                    // cycles for read/write to show
    localparam int          RUN_LIMIT = NUM_INSTR * 8 + 100;  // whole run

    logic        CLK;
    logic        rst_n;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic        read;
    logic        write;
    logic [7:0]  address;
    logic [7:0]  writedata;
    logic [7:0]  readdata;
    logic        busywait;
    logic [7:0]  mem [256];                                   // data memory model
    int          checker_errors;
    int          commits;
    int          tb_errors = 0;
    bit          done      = 1'b0;

    cpu #(.RESET_PC(RESET_PC)) u_cpu (.*);

    cpu_checker #(.RESET_PC(RESET_PC)) u_checker (
        .*,
        .error_count  (checker_errors),
        .commit_count (commits)
    );

    // loadi, lwd and swd get two slots each and illegal codes take the last two
    function automatic logic [31:0] random_instruction();
        logic [7:0] op;
        case ($urandom_range(0, 15))
            0, 1:    op = cpu_pkg::OP_LOADI;
            2:       op = cpu_pkg::OP_MOV;
            3:       op = cpu_pkg::OP_ADD;
            4:       op = cpu_pkg::OP_SUB;
            5:       op = cpu_pkg::OP_AND;
            6:       op = cpu_pkg::OP_OR;
            7:       op = cpu_pkg::OP_J;
            8:       op = cpu_pkg::OP_BEQ;
            9:       op = cpu_pkg::OP_BNE;
            10, 11:  op = cpu_pkg::OP_LWD;
            12, 13:  op = cpu_pkg::OP_SWD;
            14:      op = 8'd8 + 8'($urandom_range(0, 4));   // undecoded codes 8 to 12
            default: op = 8'hc0 | 8'($urandom);              // far outside the set
        endcase
        return {op, 24'($urandom)};
    endfunction

    task automatic finish_run();
        $display("checker errors %0d, testbench errors %0d, committed %0d",
                 checker_errors, tb_errors, commits);
        if (checker_errors == 0 && tb_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial
    begin
        for (int c = 0; c < RUN_LIMIT && !done; c++)
            @(posedge CLK);
        if (!done)
        begin
            $display("run did not finish within %0d cycles", RUN_LIMIT);
            tb_errors++;
            finish_run();
        end
    end

    initial
    begin
        logic [31:0] instr;
        int          seed_out;
        bit          seen;
        rst_n       = 1'b0;
        instruction = 32'hff00_0000;                          // undecoded opcode acts as nop
        readdata    = '0;
        busywait    = 1'b0;
        seed_out    = $urandom(SEED);
        for (int a = 0; a < 256; a++)
            mem[a] = 8'(a * 37) ^ 8'h3c;                      // odd multiplier so all bits count
        repeat (16) @(posedge CLK);
        rst_n <= 1'b1;
        for (int n = 0; n < NUM_INSTR; n++)
        begin
            instr = random_instruction();
            instruction <= instr;
            readdata    <= 8'($urandom);                      // junk unless an lwd completes
            if (instr[31:24] == cpu_pkg::OP_LWD || instr[31:24] == cpu_pkg::OP_SWD)
            begin
                busywait <= 1'b1;                             // memory sees the request first
                seen = 1'b0;
                for (int k = 0; k < REQ_LIMIT && !seen; k++)
                begin
                    @(posedge CLK);
                    seen = read | write;
                end
                if (!seen)
                begin
                    $display("no memory request within %0d cycles for opcode %0h",
                             REQ_LIMIT, instr[31:24]);
                    tb_errors++;
                    break;
                end
                repeat ($urandom_range(0, 3)) @(posedge CLK);
                busywait <= 1'b0;
                readdata <= mem[address];                     // address holds while stalled
                @(posedge CLK);                               // completing edge
                if (write)
                    mem[address] = writedata;
            end
            else
            begin
                busywait <= 1'($urandom);                     // ignored outside memory ops
                @(posedge CLK);
            end
        end
        @(negedge CLK);
        done = 1'b1;
        finish_run();
    end

endmodule

/* all.f */
src/cpu_pkg.sv
src/control_unit.sv
src/alu.sv
src/reg_file.sv
src/pc_unit.sv
src/cpu.sv
sim/cpu_checker.sv
sim/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - src/cpu_pkg.sv
  - src/control_unit.sv
  - src/alu.sv
  - src/reg_file.sv
  - src/pc_unit.sv
  - src/cpu.sv
  - target: simulation
    files:
      - sim/cpu_checker.sv
      - sim/cpu_tb.sv
